// ==== files.f ====
src/uart_jtag_pkg.sv
src/baud_tick_gen.sv
src/uart_rx.sv
src/uart_tx.sv
src/jtag_pin_driver.sv
src/uart_jtag_bridge.sv
dv/jtag_pin_driver_assertions.sv
dv/uart_jtag_bridge_tb.sv

// ==== dv/uart_jtag_bridge_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_jtag_bridge_tb;

  localparam int PRESCALE = 1;
  localparam int BIT_CLKS = 16 * (PRESCALE + 1);
  // pin decode, reply frame, random stream, hold
  localparam int NUM_CMDS = 16 + 2 + 20 + 2;
  localparam int TIMEOUT_CYCLES = NUM_CMDS * 25 * BIT_CLKS + 2000;

  logic        clk;
  logic        reset;
  logic        rx;
  logic        tdo;
  logic        tx;
  logic        tck;
  logic        tms;
  logic        tdi;

  // expected {tck, tms, tdi, reply byte} in command order
  logic [10:0] exp_q[$];
  logic [2:0]  model_pins;
  logic [15:0] lfsr;
  int          cycles = 0;
  int          errors = 0;
  int          tests = 0;
  int          sent = 0;
  int          replies = 0;

  uart_jtag_bridge #(
    .PRESCALE (PRESCALE)
  ) uart_jtag_bridge_inst (
    .clk   (clk),
    .reset (reset),
    .rx    (rx),
    .tdo   (tdo),
    .tx    (tx),
    .tck   (tck),
    .tms   (tms),
    .tdi   (tdi)
  );

  bind jtag_pin_driver jtag_pin_driver_assertions jtag_pin_driver_assertions_inst (
    .clk         (clk),
    .reset       (reset),
    .rx_done     (rx_done),
    .reply_start (reply_start),
    .tck         (tck),
    .tms         (tms),
    .tdi         (tdi)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // jtag target model trails the pins by one clock
  always @(posedge clk) begin
    tdo <= tms ^ tdi;
  end

  // ====================
  // reference model
  // ====================
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // prev_pins is {tck, tms, tdi} before this command
  function automatic logic [10:0] ref_result(input logic [7:0] cmd, input logic [2:0] prev_pins);
    logic [7:0] reply;
    reply    = 8'h00;
    // reply launches one clock after the pin update, so tdo still shows the old pins
    reply[0] = prev_pins[1] ^ prev_pins[0];
    return {cmd[3], cmd[0], cmd[1], reply};
  endfunction

  task automatic report_error(input string msg);
    errors++;
    $display("Error at %0t ns: %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input int err_mark);
    tests++;
    $display("test %s finished with %0d errors", name, errors - err_mark);
  endtask

  task automatic next_random(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b[i] = lfsr[0];
    end
  endtask

  // host serial frame with start bit, 8 data bits lsb first and stop bit
  task automatic send_byte(input logic [7:0] b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rx <= frame[i];
      repeat (BIT_CLKS - 1) @(posedge clk);
    end
  endtask

  task automatic check_hold(input int n, input logic [2:0] held);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if ({tck, tms, tdi} !== held) begin
        report_error($sformatf("pins %b left their held level %b", {tck, tms, tdi}, held));
        break;
      end
    end
  endtask

  // no second start bit may follow a reply frame
  task automatic check_tx_idle(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk);
      if (tx !== 1'b1) begin
        report_error("tx left the idle level after a reply frame");
        break;
      end
    end
  endtask

  task automatic issue_cmd(input logic [7:0] cmd, input int hold_clks);
    logic [10:0] exp;
    logic [2:0]  held;
    held = model_pins;
    exp  = ref_result(cmd, model_pins);
    exp_q.push_back(exp);
    model_pins = exp[10:8];
    sent++;
    if (hold_clks > 0) begin
      fork
        send_byte(cmd);
        check_hold(hold_clks, held);
      join
    end else begin
      send_byte(cmd);
    end
    while (replies < sent) @(negedge clk);
  endtask

  // ====================
  // reply monitor
  // ====================
  initial begin
    logic [7:0]  data;
    logic [10:0] exp;
    logic [2:0]  pins;
    logic        prev_tx;
    prev_tx = 1'b1;
    forever begin
      @(negedge clk);
      if (!reset && prev_tx === 1'b1 && tx === 1'b0) begin
        pins = {tck, tms, tdi};
        repeat (BIT_CLKS / 2) @(negedge clk);
        if (tx !== 1'b0) begin
          report_error("reply start bit is not low at mid-bit");
        end
        for (int i = 0; i < 8; i++) begin
          repeat (BIT_CLKS) @(negedge clk);
          data[i] = tx;
        end
        repeat (BIT_CLKS) @(negedge clk);
        if (tx !== 1'b1) begin
          report_error("reply stop bit is not high");
        end
        if (exp_q.size() == 0) begin
          report_error("reply frame seen with no command outstanding");
        end else begin
          exp = exp_q.pop_front();
          if (pins !== exp[10:8]) begin
            report_error($sformatf("pins %b, expected %b", pins, exp[10:8]));
          end
          if (data !== exp[7:0]) begin
            report_error($sformatf("reply %h, expected %h", data, exp[7:0]));
          end
        end
        replies++;
      end
      prev_tx = tx;
    end
  end

  // ====================
  // stimulus
  // ====================
  initial begin
    int         err_mark;
    logic [7:0] cmd;
    rx         = 1'b1;
    tdo        = 1'b0;
    reset      = 1'b1;
    model_pins = 3'b000;
    lfsr       = 16'd18;
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    err_mark = errors;
    repeat (200) begin
      @(negedge clk);
      if ({tck, tms, tdi} !== 3'b000 || tx !== 1'b1) begin
        report_error("pins not low or tx not high while idle after reset");
      end
    end
    finish_test("reset state", err_mark);

    // upper bits held high throughout
    err_mark = errors;
    for (int v = 0; v < 16; v++) begin
      issue_cmd(8'hF0 | 8'(v), 0);
    end
    finish_test("pin decode", err_mark);

    err_mark = errors;
    issue_cmd(8'h01, 0);
    check_tx_idle(12 * BIT_CLKS);
    issue_cmd(8'h02, 0);
    check_tx_idle(12 * BIT_CLKS);
    if (replies != sent) begin
      report_error($sformatf("%0d reply frames for %0d commands", replies, sent));
    end
    finish_test("reply frame", err_mark);

    err_mark = errors;
    repeat (20) begin
      next_random(cmd);
      issue_cmd(cmd, 0);
    end
    finish_test("random stream", err_mark);

    err_mark = errors;
    check_hold(300, model_pins);
    issue_cmd(8'h0B, 9 * BIT_CLKS);
    check_hold(300, model_pins);
    issue_cmd(8'h04, 9 * BIT_CLKS);
    finish_test("hold between commands", err_mark);

    repeat (3 * BIT_CLKS) @(negedge clk);
    if (replies != sent || exp_q.size() != 0) begin
      report_error($sformatf("%0d reply frames for %0d commands", replies, sent));
    end
    errors += uart_jtag_bridge_inst.jtag_pin_driver_inst.jtag_pin_driver_assertions_inst.fail_count;
    $display("%0d tests, %0d commands, %0d replies, %0d errors", tests, sent, replies, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/jtag_pin_driver_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module jtag_pin_driver_assertions (
  input logic clk,
  input logic reset,
  input logic rx_done,
  input logic reply_start,
  input logic tck,
  input logic tms,
  input logic tdi
);

  int fail_count = 0;

  // ====================
  // reply launch
  // ====================
  // one clock from received byte to reply
  a_reply_after_done: assert property (
    @(posedge clk) disable iff (reset) rx_done |=> reply_start
  ) else begin
    $error("reply_start missing one cycle after rx_done");
    fail_count++;
  end

  a_reply_has_cause: assert property (
    @(posedge clk) disable iff (reset) reply_start |-> $past(rx_done)
  ) else begin
    $error("reply_start without rx_done in the cycle before");
    fail_count++;
  end

  // ====================
  // pin updates
  // ====================
  a_pins_on_command: assert property (
    @(posedge clk) disable iff (reset) !$stable({tck, tms, tdi}) |-> $past(rx_done)
  ) else begin
    $error("jtag pins changed without a received command");
    fail_count++;
  end

endmodule

`default_nettype wire

// ==== src/uart_jtag_bridge.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_jtag_bridge
  import uart_jtag_pkg::*;
#(
  parameter logic [PRESCALE_W-1:0] PRESCALE = 1
) (
  input  logic clk,
  input  logic reset,
  input  logic rx,
  input  logic tdo,
  output logic tx,
  output logic tck,
  output logic tms,
  output logic tdi
);

  logic                 tick;
  logic [DATA_BITS-1:0] rx_byte;
  logic                 rx_done;
  logic                 reply_start;
  logic [DATA_BITS-1:0] reply_byte;

  // baud rate = clk / ((PRESCALE+1) * OVERSAMPLE)
  baud_tick_gen #(
    .PRESCALE (PRESCALE)
  ) baud_tick_gen_inst (
    .clk   (clk),
    .reset (reset),
    .tick  (tick)
  );

  uart_rx uart_rx_inst (
    .clk     (clk),
    .reset   (reset),
    .tick    (tick),
    .rx      (rx),
    .rx_byte (rx_byte),
    .rx_done (rx_done)
  );

  jtag_pin_driver jtag_pin_driver_inst (
    .clk         (clk),
    .reset       (reset),
    .rx_byte     (rx_byte),
    .rx_done     (rx_done),
    .tdo         (tdo),
    .tck         (tck),
    .tms         (tms),
    .tdi         (tdi),
    .reply_start (reply_start),
    .reply_byte  (reply_byte)
  );

  uart_tx uart_tx_inst (
    .clk      (clk),
    .reset    (reset),
    .tick     (tick),
    .tx_start (reply_start),
    .tx_byte  (reply_byte),
    .tx       (tx)
  );

endmodule

`default_nettype wire

// ==== src/jtag_pin_driver.sv ====
`timescale 1ns/100ps
`default_nettype none

module jtag_pin_driver
  import uart_jtag_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic [DATA_BITS-1:0] rx_byte,
  input  logic                 rx_done,
  input  logic                 tdo,
  output logic                 tck,
  output logic                 tms,
  output logic                 tdi,
  output logic                 reply_start,
  output logic [DATA_BITS-1:0] reply_byte
);

  // pins hold until the next command byte
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      tck         <= 1'b0;
      tms         <= 1'b0;
      tdi         <= 1'b0;
      reply_start <= 1'b0;
    end else begin
      reply_start <= rx_done;
      if (rx_done) begin
        tms <= rx_byte[CMD_TMS_BIT];
        tdi <= rx_byte[CMD_TDI_BIT];
        tck <= rx_byte[CMD_TCK_BIT];
      end
    end
  end

  // live tdo, captured by the transmitter on reply_start
  always_comb begin
    reply_byte                = '0;
    reply_byte[REPLY_TDO_BIT] = tdo;
  end

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx
  import uart_jtag_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 tx_start,
  input  logic [DATA_BITS-1:0] tx_byte,
  output logic                 tx
);

  uart_state_e           state;
  uart_state_e           state_next;
  logic [TICK_CNT_W-1:0] tick_cnt;
  logic [TICK_CNT_W-1:0] tick_cnt_next;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt_next;
  logic [DATA_BITS-1:0]  shift_reg;
  logic                  load;
  logic                  shift;
  logic                  tx_reg;
  logic                  tx_next;
  logic                  tx_done;
  logic                  last_tick;

  assign last_tick = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));

  // ====================
  // state registers
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      tx_reg   <= 1'b1;
    end else begin
      state    <= state_next;
      tick_cnt <= tick_cnt_next;
      bit_cnt  <= bit_cnt_next;
      tx_reg   <= tx_next;
    end
  end

  // outgoing byte, lsb leaves first
  always_ff @(posedge clk) begin
    if (load) begin
      shift_reg <= tx_byte;
    end else if (shift) begin
      shift_reg <= shift_reg >> 1;
    end
  end

  assign tx = tx_reg;

  // ====================
  // next state
  // ====================
  always_comb begin
    state_next    = state;
    tick_cnt_next = tick_cnt;
    bit_cnt_next  = bit_cnt;
    tx_next       = tx_reg;
    load          = 1'b0;
    shift         = 1'b0;
    tx_done       = 1'b0;

    case (state)
      ST_IDLE: begin
        tx_next = 1'b1;
        // a start pulse while busy is dropped
        if (tx_start) begin
          state_next    = ST_START;
          tick_cnt_next = '0;
          load          = 1'b1;
        end
      end

      ST_START: begin
        tx_next = 1'b0;
        if (last_tick) begin
          state_next    = ST_DATA;
          tick_cnt_next = '0;
          bit_cnt_next  = '0;
        end else if (tick) begin
          tick_cnt_next = tick_cnt + 1'b1;
        end
      end

      ST_DATA: begin
        tx_next = shift_reg[0];
        if (last_tick) begin
          tick_cnt_next = '0;
          shift         = 1'b1;
          if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
            state_next = ST_STOP;
          end else begin
            bit_cnt_next = bit_cnt + 1'b1;
          end
        end else if (tick) begin
          tick_cnt_next = tick_cnt + 1'b1;
        end
      end

      ST_STOP: begin
        tx_next = 1'b1;
        // end of frame after one full stop bit
        tx_done = last_tick;
        if (tx_done) begin
          state_next = ST_IDLE;
        end else if (tick) begin
          tick_cnt_next = tick_cnt + 1'b1;
        end
      end

      default: state_next = ST_IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/uart_rx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_rx
  import uart_jtag_pkg::*;
(
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 tick,
  input  logic                 rx,
  output logic [DATA_BITS-1:0] rx_byte,
  output logic                 rx_done
);

  uart_state_e           state;
  uart_state_e           state_next;
  logic [TICK_CNT_W-1:0] tick_cnt;
  logic [TICK_CNT_W-1:0] tick_cnt_next;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt_next;
  logic [DATA_BITS-1:0]  shift_reg;
  logic                  sample;
  logic                  last_tick;

  // last oversampling tick of a bit period
  assign last_tick = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));

  // ====================
  // state registers
  // ====================
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state    <= ST_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      state    <= state_next;
      tick_cnt <= tick_cnt_next;
      bit_cnt  <= bit_cnt_next;
    end
  end

  // data bits arrive lsb first, so shift in from the top
  always_ff @(posedge clk) begin
    if (sample) begin
      shift_reg <= {rx, shift_reg[DATA_BITS-1:1]};
    end
  end

  assign rx_byte = shift_reg;

  // ====================
  // next state
  // ====================
  always_comb begin
    state_next    = state;
    tick_cnt_next = tick_cnt;
    bit_cnt_next  = bit_cnt;
    sample        = 1'b0;
    rx_done       = 1'b0;

    case (state)
      ST_IDLE: begin
        // falling edge of the start bit
        if (!rx) begin
          state_next    = ST_START;
          tick_cnt_next = '0;
        end
      end

      ST_START: begin
        if (tick) begin
          if (tick_cnt == TICK_CNT_W'(START_MID_TICKS - 1)) begin
            state_next    = ST_DATA;
            tick_cnt_next = '0;
            bit_cnt_next  = '0;
          end else begin
            tick_cnt_next = tick_cnt + 1'b1;
          end
        end
      end

      ST_DATA: begin
        if (last_tick) begin
          tick_cnt_next = '0;
          sample        = 1'b1;
          if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1)) begin
            state_next = ST_STOP;
          end else begin
            bit_cnt_next = bit_cnt + 1'b1;
          end
        end else if (tick) begin
          tick_cnt_next = tick_cnt + 1'b1;
        end
      end

      ST_STOP: begin
        // stop level is not checked
        if (last_tick) begin
          state_next = ST_IDLE;
          rx_done    = 1'b1;
        end else if (tick) begin
          tick_cnt_next = tick_cnt + 1'b1;
        end
      end

      default: state_next = ST_IDLE;
    endcase
  end

endmodule

`default_nettype wire

// ==== src/baud_tick_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module baud_tick_gen
  import uart_jtag_pkg::*;
#(
  parameter logic [PRESCALE_W-1:0] PRESCALE = 1
) (
  input  logic clk,
  input  logic reset,
  output logic tick
);

  logic [PRESCALE_W-1:0] count;
  logic                  wrap;

  // one tick every PRESCALE+1 clocks
  assign wrap = (count == PRESCALE);
  assign tick = wrap;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else if (wrap) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== src/uart_jtag_pkg.sv ====
`default_nettype none

package uart_jtag_pkg;

  // ====================
  // serial frame
  // ====================
  localparam int PRESCALE_W      = 16;
  localparam int DATA_BITS       = 8;
  localparam int OVERSAMPLE      = 16;
  localparam int TICK_CNT_W      = 4;
  localparam int BIT_CNT_W       = 3;
  // half a bit of ticks puts data sampling at mid-bit
  localparam int START_MID_TICKS = 8;

  // ====================
  // command and reply bytes
  // ====================
  localparam int CMD_TMS_BIT     = 0;
  localparam int CMD_TDI_BIT     = 1;
  localparam int CMD_TCK_BIT     = 3;
  localparam int REPLY_TDO_BIT   = 0;

  typedef enum logic [1:0] {
    ST_IDLE  = 2'b00,
    ST_START = 2'b01,
    ST_DATA  = 2'b11,
    ST_STOP  = 2'b10
  } uart_state_e;

endpackage

`default_nettype wire
